//--- build.f
design/commitPkg.sv
design/writeback.sv
design/regFile.sv
design/hiLoReg.sv
design/cp0Regs.sv
design/commitTop.sv
tb/commitTop_properties.sv
tb/commitTb.sv

//--- design/commitPkg.sv
// shared types for the commit end of the dual-issue pipeline
package commitPkg;

    // widths
    localparam int WORD_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int CP0_ADDR_WIDTH = 5;

    // number of slots retiring per cycle
    localparam int SLOT_COUNT = 2;

    // data or address word
    typedef logic [WORD_WIDTH-1:0] word_t;

    // general register number
    typedef logic [REG_ADDR_WIDTH-1:0] cregAddr_t;

    // cp0 register number
    typedef logic [CP0_ADDR_WIDTH-1:0] cp0Addr_t;

    // cp0 register numbers that exist here
    localparam cp0Addr_t CP0_STATUS = 5'd12;
    localparam cp0Addr_t CP0_EPC = 5'd14;

    // exl position inside status
    localparam int STATUS_EXL_BIT = 1;

    // cp0 event carried by a slot
    typedef enum logic [1:0] {
        CP0_NONE = 2'd0,
        CP0_EXCEPTION = 2'd1,
        CP0_ERET = 2'd2
    } cp0Type_e;

    // per-slot control flags from decode
    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic hiToReg;
        logic loToReg;
        logic cp0ToReg;
        logic hiWrite;
        logic loWrite;
        logic cp0Write;
    } slotCtl_t;

    // one memory-stage slot
    typedef struct packed {
        logic valid;
        word_t pc;
        cregAddr_t rdst;
        word_t aluOut;
        word_t memRd;
        cp0Addr_t cp0Addr;
        cp0Type_e cp0Type;
        slotCtl_t ctl;
    } memoryData_t;

    // one register-file write, valid is the write enable
    typedef struct packed {
        logic valid;
        word_t pc;
        cregAddr_t wa;
        word_t wd;
        slotCtl_t ctl;
    } writebackData_t;

endpackage

//--- design/commitTop.sv
`timescale 1ns/1ns

// commit end: writeback, register file, hi/lo and cp0
module commitTop (
    input logic clk,
    input logic rst,
    input commitPkg::memoryData_t [1:0] dataM,
    input commitPkg::cregAddr_t [1:0] raddr,
    output commitPkg::word_t [1:0] rdata,
    output commitPkg::word_t hiRd,
    output commitPkg::word_t loRd,
    output commitPkg::word_t epc,
    output logic exl
);

    // register writes from writeback
    commitPkg::writebackData_t [1:0] dataW;

    // cp0 read value for mfc0
    commitPkg::word_t cp0Rd;

    // result selection per slot
    writeback writeback_i (
        .dataM(dataM),
        .hiRd(hiRd),
        .loRd(loRd),
        .cp0Rd(cp0Rd),
        .dataW(dataW)
    );

    // shared general registers
    regFile regFile_i (
        .clk(clk),
        .rst(rst),
        .dataW(dataW),
        .raddr(raddr),
        .rdata(rdata)
    );

    // mult/div results
    hiLoReg hiLoReg_i (
        .clk(clk),
        .rst(rst),
        .dataM(dataM),
        .hiRd(hiRd),
        .loRd(loRd)
    );

    // status and epc
    cp0Regs cp0Regs_i (
        .clk(clk),
        .rst(rst),
        .dataM(dataM),
        .cp0Rd(cp0Rd),
        .epc(epc),
        .exl(exl)
    );

endmodule

//--- design/cp0Regs.sv
`timescale 1ns/1ns

// cp0 status and epc, updated from slot 0 only
module cp0Regs (
    input logic clk,
    input logic rst,
    input commitPkg::memoryData_t [1:0] dataM,
    output commitPkg::word_t cp0Rd,
    output commitPkg::word_t epc,
    output logic exl
);

    commitPkg::word_t statusQ;
    commitPkg::word_t epcQ;

    // cp0 moves and events only ever come in slot 0
    commitPkg::memoryData_t slot0;

    assign slot0 = dataM[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            statusQ <= '0;
            epcQ <= '0;
        end else if (slot0.valid) begin
            case (slot0.cp0Type)
                commitPkg::CP0_EXCEPTION: begin
                    // save faulting pc, enter exception level
                    epcQ <= slot0.pc;
                    statusQ[commitPkg::STATUS_EXL_BIT] <= 1'b1;
                end
                commitPkg::CP0_ERET: begin
                    // return, epc stays
                    statusQ[commitPkg::STATUS_EXL_BIT] <= 1'b0;
                end
                default: begin
                    // mtc0, only when no event
                    if (slot0.ctl.cp0Write) begin
                        if (slot0.cp0Addr == commitPkg::CP0_STATUS) begin
                            statusQ <= slot0.aluOut;
                        end else if (slot0.cp0Addr == commitPkg::CP0_EPC) begin
                            epcQ <= slot0.aluOut;
                        end
                    end
                end
            endcase
        end
    end

    // read port for mfc0, old value in same cycle
    always_comb begin
        case (slot0.cp0Addr)
            commitPkg::CP0_STATUS: cp0Rd = statusQ;
            commitPkg::CP0_EPC: cp0Rd = epcQ;
            // unimplemented registers read zero
            default: cp0Rd = '0;
        endcase
    end

    assign epc = epcQ;
    assign exl = statusQ[commitPkg::STATUS_EXL_BIT];

endmodule

//--- design/hiLoReg.sv
`timescale 1ns/1ns

// hi and lo result registers of the multiply/divide path
module hiLoReg (
    input logic clk,
    input logic rst,
    input commitPkg::memoryData_t [1:0] dataM,
    output commitPkg::word_t hiRd,
    output commitPkg::word_t loRd
);

    commitPkg::word_t hiQ;
    commitPkg::word_t loQ;

    // slot may commit to hi/lo
    logic [commitPkg::SLOT_COUNT-1:0] slotOk;

    always_comb begin
        for (int i = 0; i < commitPkg::SLOT_COUNT; ++i) begin
            // an excepting slot leaves hi/lo alone
            slotOk[i] = dataM[i].valid && (dataM[i].cp0Type != commitPkg::CP0_EXCEPTION);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hiQ <= '0;
            loQ <= '0;
        end else begin
            for (int i = 0; i < commitPkg::SLOT_COUNT; ++i) begin
                // later iteration is slot 1, so it wins
                if (slotOk[i] && dataM[i].ctl.hiWrite) begin
                    hiQ <= dataM[i].aluOut;
                end
                if (slotOk[i] && dataM[i].ctl.loWrite) begin
                    loQ <= dataM[i].aluOut;
                end
            end
        end
    end

    // same-cycle readers see the old value
    assign hiRd = hiQ;
    assign loRd = loQ;

endmodule

//--- design/regFile.sv
`timescale 1ns/1ns

// 32 x 32 general registers, two write ports and two read ports
module regFile (
    input logic clk,
    input logic rst,
    input commitPkg::writebackData_t [1:0] dataW,
    input commitPkg::cregAddr_t [1:0] raddr,
    output commitPkg::word_t [1:0] rdata
);

    // register 0 is not stored
    commitPkg::word_t regs [31:1];

    // per-port write enable with register 0 dropped
    logic [commitPkg::SLOT_COUNT-1:0] wen;

    always_comb begin
        for (int i = 0; i < commitPkg::SLOT_COUNT; ++i) begin
            wen[i] = dataW[i].valid && (dataW[i].wa != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 1; r < 32; ++r) begin
                regs[r] <= '0;
            end
        end else begin
            // slot 0 first
            if (wen[0]) begin
                regs[dataW[0].wa] <= dataW[0].wd;
            end
            // younger slot written last, wins on same address
            if (wen[1]) begin
                regs[dataW[1].wa] <= dataW[1].wd;
            end
        end
    end

    // combinational read of stored value
    always_comb begin
        for (int i = 0; i < commitPkg::SLOT_COUNT; ++i) begin
            if (raddr[i] == '0) begin
                rdata[i] = '0;
            end else begin
                rdata[i] = regs[raddr[i]];
            end
        end
    end

endmodule

//--- design/writeback.sv
`timescale 1ns/1ns

// picks the result of each slot and builds the register write
module writeback (
    input commitPkg::memoryData_t [1:0] dataM,
    input commitPkg::word_t hiRd,
    input commitPkg::word_t loRd,
    input commitPkg::word_t cp0Rd,
    output commitPkg::writebackData_t [1:0] dataW
);

    // selected write data per slot
    commitPkg::word_t wdSel [commitPkg::SLOT_COUNT];

    // slot carries an exception or eret
    logic [commitPkg::SLOT_COUNT-1:0] cp0Event;

    always_comb begin
        for (int i = 0; i < commitPkg::SLOT_COUNT; ++i) begin
            // base value, load data first
            if (dataM[i].ctl.memToReg) begin
                wdSel[i] = dataM[i].memRd;
            end else if (dataM[i].ctl.regWrite) begin
                wdSel[i] = dataM[i].aluOut;
            end else begin
                wdSel[i] = '0;
            end

            // later checks override earlier ones
            if (dataM[i].ctl.cp0ToReg) begin
                wdSel[i] = cp0Rd;
            end
            if (dataM[i].ctl.loToReg) begin
                wdSel[i] = loRd;
            end
            // hi is checked last, so it wins
            if (dataM[i].ctl.hiToReg) begin
                wdSel[i] = hiRd;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < commitPkg::SLOT_COUNT; ++i) begin
            cp0Event[i] = (dataM[i].cp0Type == commitPkg::CP0_EXCEPTION) ||
                          (dataM[i].cp0Type == commitPkg::CP0_ERET);
        end
    end

    always_comb begin
        for (int i = 0; i < commitPkg::SLOT_COUNT; ++i) begin
            // no register write from an excepting or eret slot
            if (cp0Event[i]) begin
                dataW[i].valid = 1'b0;
            end else begin
                dataW[i].valid = dataM[i].valid && dataM[i].ctl.regWrite;
            end
            dataW[i].pc = dataM[i].pc;
            dataW[i].wa = dataM[i].rdst;
            dataW[i].wd = wdSel[i];
            // control flags travel along unchanged
            dataW[i].ctl = dataM[i].ctl;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# compile and run the commit testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module commitTb -f build.f -o commitSim &&
./obj_dir/commitSim | tee /dev/stderr | grep -q "All checks passed" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }

//--- tb/commitTb.sv
`timescale 1ns/1ns

// testbench for the commit end, table driven
module commitTb;

    // one table row, checked one cycle after it is driven
    typedef struct packed {
        commitPkg::memoryData_t s0;
        commitPkg::memoryData_t s1;
        commitPkg::cregAddr_t ra0;
        commitPkg::cregAddr_t ra1;
        commitPkg::word_t expRd0;
        commitPkg::word_t expRd1;
        commitPkg::word_t expHi;
        commitPkg::word_t expLo;
        commitPkg::word_t expEpc;
        logic expExl;
        logic randFill;
    } row_t;

    logic clk;
    logic rst;
    commitPkg::memoryData_t [1:0] dataM;
    commitPkg::cregAddr_t [1:0] raddr;
    commitPkg::word_t [1:0] rdata;
    commitPkg::word_t hiRd;
    commitPkg::word_t loRd;
    commitPkg::word_t epc;
    logic exl;

    row_t rows[$];
    string names[$];
    int watchdogLimit;

    commitTop commitTop_i (
        .clk(clk),
        .rst(rst),
        .dataM(dataM),
        .raddr(raddr),
        .rdata(rdata),
        .hiRd(hiRd),
        .loRd(loRd),
        .epc(epc),
        .exl(exl)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkWord(input string name, input commitPkg::word_t expected,
                             input commitPkg::word_t actual);
        if (actual !== expected) begin
            failRun($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("[FAIL] %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // flag order follows slotCtl_t
    function automatic commitPkg::slotCtl_t makeCtl(input logic regWrite, input logic memToReg,
            input logic hiToReg, input logic loToReg, input logic cp0ToReg,
            input logic hiWrite, input logic loWrite, input logic cp0Write);
        commitPkg::slotCtl_t c;
        c = {regWrite, memToReg, hiToReg, loToReg, cp0ToReg, hiWrite, loWrite, cp0Write};
        return c;
    endfunction

    function automatic commitPkg::memoryData_t makeSlot(input logic valid,
            input commitPkg::word_t pc, input commitPkg::cregAddr_t rdst,
            input commitPkg::word_t aluOut, input commitPkg::word_t memRd,
            input commitPkg::cp0Addr_t cp0Addr, input commitPkg::cp0Type_e cp0Type,
            input commitPkg::slotCtl_t ctl);
        commitPkg::memoryData_t s;
        s.valid = valid;
        s.pc = pc;
        s.rdst = rdst;
        s.aluOut = aluOut;
        s.memRd = memRd;
        s.cp0Addr = cp0Addr;
        s.cp0Type = cp0Type;
        s.ctl = ctl;
        return s;
    endfunction

    task automatic addRow(input string name, input commitPkg::memoryData_t s0,
            input commitPkg::memoryData_t s1, input commitPkg::cregAddr_t ra0,
            input commitPkg::cregAddr_t ra1, input commitPkg::word_t expRd0,
            input commitPkg::word_t expRd1, input commitPkg::word_t expHi,
            input commitPkg::word_t expLo, input commitPkg::word_t expEpc,
            input logic expExl, input logic randFill);
        row_t r;
        r = {s0, s1, ra0, ra1, expRd0, expRd1, expHi, expLo, expEpc, expExl, randFill};
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic buildTable();
        commitPkg::memoryData_t idle;
        commitPkg::slotCtl_t ctlNone;
        commitPkg::slotCtl_t ctlAlu;
        commitPkg::slotCtl_t ctlLoad;
        commitPkg::slotCtl_t ctlHiW;
        commitPkg::slotCtl_t ctlLoW;
        commitPkg::slotCtl_t ctlMtc0;
        commitPkg::slotCtl_t ctlMfc0;
        ctlNone = makeCtl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        ctlAlu = makeCtl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        ctlLoad = makeCtl(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        ctlHiW = makeCtl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        ctlLoW = makeCtl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        ctlMtc0 = makeCtl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        ctlMfc0 = makeCtl(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        idle = makeSlot(1'b0, '0, 5'd0, '0, '0, 5'd0, commitPkg::CP0_NONE, ctlNone);

        // result selection
        addRow("alu write", makeSlot(1'b1, 32'h0040_0000, 5'd1, 32'h1111_1111, 32'h0, 5'd0,
            commitPkg::CP0_NONE, ctlAlu), idle, 5'd1, 5'd0,
            32'h1111_1111, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
        // load data wins over alu value
        addRow("load write", makeSlot(1'b1, 32'h0040_0004, 5'd2, 32'hdead_beef, 32'h2222_2222,
            5'd0, commitPkg::CP0_NONE, ctlLoad), idle, 5'd2, 5'd1,
            32'h2222_2222, 32'h1111_1111, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
        addRow("regWrite clear", makeSlot(1'b1, 32'h0040_0008, 5'd1, 32'h9999_9999, 32'h0,
            5'd0, commitPkg::CP0_NONE, ctlNone), idle, 5'd1, 5'd2,
            32'h1111_1111, 32'h2222_2222, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);

        // dual issue
        addRow("dual write", makeSlot(1'b1, 32'h0040_000c, 5'd3, 32'h3333_3333, 32'h0, 5'd0,
            commitPkg::CP0_NONE, ctlAlu), makeSlot(1'b1, 32'h0040_0010, 5'd4, 32'h4444_4444,
            32'h0, 5'd0, commitPkg::CP0_NONE, ctlAlu), 5'd3, 5'd4,
            32'h3333_3333, 32'h4444_4444, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
        addRow("same reg conflict", makeSlot(1'b1, 32'h0040_0014, 5'd5, 32'h5555_0000, 32'h0,
            5'd0, commitPkg::CP0_NONE, ctlAlu), makeSlot(1'b1, 32'h0040_0018, 5'd5,
            32'h5555_1111, 32'h0, 5'd0, commitPkg::CP0_NONE, ctlAlu), 5'd5, 5'd3,
            32'h5555_1111, 32'h3333_3333, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
        addRow("write r0", makeSlot(1'b1, 32'h0040_001c, 5'd0, 32'hffff_ffff, 32'h0, 5'd0,
            commitPkg::CP0_NONE, ctlAlu), makeSlot(1'b1, 32'h0040_0020, 5'd0, 32'h0,
            32'heeee_eeee, 5'd0, commitPkg::CP0_NONE, ctlLoad), 5'd0, 5'd5,
            32'h0, 32'h5555_1111, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);

        // hi and lo writes
        addRow("hi s0 lo s1", makeSlot(1'b1, 32'h0040_0024, 5'd0, 32'haaaa_0001, 32'h0, 5'd0,
            commitPkg::CP0_NONE, ctlHiW), makeSlot(1'b1, 32'h0040_0028, 5'd0, 32'hbbbb_0001,
            32'h0, 5'd0, commitPkg::CP0_NONE, ctlLoW), 5'd1, 5'd2,
            32'h1111_1111, 32'h2222_2222, 32'haaaa_0001, 32'hbbbb_0001, 32'h0, 1'b0, 1'b0);
        addRow("lo s0 hi s1", makeSlot(1'b1, 32'h0040_002c, 5'd0, 32'hbbbb_0002, 32'h0, 5'd0,
            commitPkg::CP0_NONE, ctlLoW), makeSlot(1'b1, 32'h0040_0030, 5'd0, 32'haaaa_0002,
            32'h0, 5'd0, commitPkg::CP0_NONE, ctlHiW), 5'd1, 5'd2,
            32'h1111_1111, 32'h2222_2222, 32'haaaa_0002, 32'hbbbb_0002, 32'h0, 1'b0, 1'b0);
        // slot 1 takes hi, lo only from slot 0
        addRow("hi conflict", makeSlot(1'b1, 32'h0040_0034, 5'd0, 32'hc0c0_c0c0, 32'h0, 5'd0,
            commitPkg::CP0_NONE, makeCtl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0)),
            makeSlot(1'b1, 32'h0040_0038, 5'd0, 32'hd1d1_d1d1, 32'h0, 5'd0,
            commitPkg::CP0_NONE, ctlHiW), 5'd1, 5'd2,
            32'h1111_1111, 32'h2222_2222, 32'hd1d1_d1d1, 32'hc0c0_c0c0, 32'h0, 1'b0, 1'b0);
        addRow("mfhi mflo", makeSlot(1'b1, 32'h0040_003c, 5'd6, 32'h0, 32'h0, 5'd0,
            commitPkg::CP0_NONE, makeCtl(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0)),
            makeSlot(1'b1, 32'h0040_0040, 5'd7, 32'h0, 32'h0, 5'd0, commitPkg::CP0_NONE,
            makeCtl(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0)), 5'd6, 5'd7,
            32'hd1d1_d1d1, 32'hc0c0_c0c0, 32'hd1d1_d1d1, 32'hc0c0_c0c0, 32'h0, 1'b0, 1'b0);

        // mtc0 and mfc0, status value carries exl
        addRow("mtc0 status", makeSlot(1'b1, 32'h0040_0044, 5'd0, 32'h0000_ff02, 32'h0,
            commitPkg::CP0_STATUS, commitPkg::CP0_NONE, ctlMtc0), idle, 5'd6, 5'd7,
            32'hd1d1_d1d1, 32'hc0c0_c0c0, 32'hd1d1_d1d1, 32'hc0c0_c0c0, 32'h0, 1'b1, 1'b0);
        addRow("mtc0 epc", makeSlot(1'b1, 32'h0040_0048, 5'd0, 32'h0040_0100, 32'h0,
            commitPkg::CP0_EPC, commitPkg::CP0_NONE, ctlMtc0), idle, 5'd6, 5'd7, 32'hd1d1_d1d1,
            32'hc0c0_c0c0, 32'hd1d1_d1d1, 32'hc0c0_c0c0, 32'h0040_0100, 1'b1, 1'b0);
        addRow("mfc0 status", makeSlot(1'b1, 32'h0040_004c, 5'd8, 32'h1234_5678, 32'h0,
            commitPkg::CP0_STATUS, commitPkg::CP0_NONE, ctlMfc0), idle, 5'd8, 5'd0,
            32'h0000_ff02, 32'h0, 32'hd1d1_d1d1, 32'hc0c0_c0c0, 32'h0040_0100, 1'b1, 1'b0);
        // override order, lo beats cp0, hi beats both
        addRow("lo over cp0", makeSlot(1'b1, 32'h0040_0050, 5'd9, 32'h0, 32'h0,
            commitPkg::CP0_STATUS, commitPkg::CP0_NONE,
            makeCtl(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0)), idle, 5'd9, 5'd8,
            32'hc0c0_c0c0, 32'h0000_ff02, 32'hd1d1_d1d1, 32'hc0c0_c0c0, 32'h0040_0100,
            1'b1, 1'b0);
        addRow("hi over all", makeSlot(1'b1, 32'h0040_0054, 5'd10, 32'h0, 32'h0,
            commitPkg::CP0_STATUS, commitPkg::CP0_NONE,
            makeCtl(1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0)), idle, 5'd10, 5'd9,
            32'hd1d1_d1d1, 32'hc0c0_c0c0, 32'hd1d1_d1d1, 32'hc0c0_c0c0, 32'h0040_0100,
            1'b1, 1'b0);
        addRow("clear status", makeSlot(1'b1, 32'h0040_0058, 5'd0, 32'h0, 32'h0,
            commitPkg::CP0_STATUS, commitPkg::CP0_NONE, ctlMtc0), idle, 5'd10, 5'd0,
            32'hd1d1_d1d1, 32'h0, 32'hd1d1_d1d1, 32'hc0c0_c0c0, 32'h0040_0100, 1'b0, 1'b0);

        // exception keeps r11 and hi, random data
        addRow("exception", makeSlot(1'b1, 32'h0040_0200, 5'd11, 32'h0, 32'h0, 5'd0,
            commitPkg::CP0_EXCEPTION, makeCtl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0)),
            idle, 5'd11, 5'd10, 32'h0, 32'hd1d1_d1d1, 32'hd1d1_d1d1, 32'hc0c0_c0c0,
            32'h0040_0200, 1'b1, 1'b1);
        addRow("eret", makeSlot(1'b1, 32'h0040_0300, 5'd12, 32'h0, 32'h0, 5'd0,
            commitPkg::CP0_ERET, ctlAlu), idle, 5'd12, 5'd11, 32'h0, 32'h0, 32'hd1d1_d1d1,
            32'hc0c0_c0c0, 32'h0040_0200, 1'b0, 1'b1);
        addRow("mfc0 epc", makeSlot(1'b1, 32'h0040_0304, 5'd13, 32'h0, 32'h0,
            commitPkg::CP0_EPC, commitPkg::CP0_NONE, ctlMfc0), idle, 5'd13, 5'd1,
            32'h0040_0200, 32'h1111_1111, 32'hd1d1_d1d1, 32'hc0c0_c0c0, 32'h0040_0200,
            1'b0, 1'b0);
    endtask

    task automatic applyRow(input int idx);
        row_t r;
        r = rows[idx];
        // data fields unused by these rows get random values
        if (r.randFill) begin
            r.s0.aluOut = $urandom();
            r.s0.memRd = $urandom();
            r.s1.aluOut = $urandom();
            r.s1.memRd = $urandom();
        end
        dataM[0] = r.s0;
        dataM[1] = r.s1;
        raddr[0] = r.ra0;
        raddr[1] = r.ra1;
    endtask

    task automatic checkRow(input int idx);
        row_t r;
        r = rows[idx];
        checkWord({names[idx], " rdata0"}, r.expRd0, rdata[0]);
        checkWord({names[idx], " rdata1"}, r.expRd1, rdata[1]);
        checkWord({names[idx], " hiRd"}, r.expHi, hiRd);
        checkWord({names[idx], " loRd"}, r.expLo, loRd);
        checkWord({names[idx], " epc"}, r.expEpc, epc);
        checkBit({names[idx], " exl"}, r.expExl, exl);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        dataM = '0;
        raddr = '0;
        void'($urandom(98625));
        buildTable();

        // run limit from table length plus margin
        watchdogLimit = (rows.size() + 10) * 40;
        fork
            begin
                #(watchdogLimit);
                failRun("watchdog timeout: test table did not finish in time");
            end
        join_none

        repeat (2) @(posedge clk);
        #2 rst = 1'b0;

        // check previous row just after the edge, drive next one at +2 ns
        for (int i = 0; i < rows.size(); ++i) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                checkRow(i - 1);
            end
            #1;
            applyRow(i);
        end
        @(posedge clk);
        #1;
        checkRow(rows.size() - 1);

        $display("All checks passed");
        $finish;
    end

endmodule

//--- tb/commitTop_properties.sv
`timescale 1ns/1ns

// checks on the commit end bound into commitTop
module commitTopProperties (
    input logic clk,
    input logic rst,
    input commitPkg::memoryData_t [1:0] dataM,
    input commitPkg::writebackData_t [1:0] dataW,
    input commitPkg::cregAddr_t [1:0] raddr,
    input commitPkg::word_t [1:0] rdata,
    input logic exl
);

    // register 0 reads zero on both ports
    zeroRead0: assert property (@(posedge clk) disable iff (rst)
        (raddr[0] == '0) |-> (rdata[0] == '0))
        else $error("read port 0 returned nonzero data for register 0");

    zeroRead1: assert property (@(posedge clk) disable iff (rst)
        (raddr[1] == '0) |-> (rdata[1] == '0))
        else $error("read port 1 returned nonzero data for register 0");

    // exception in slot 0 raises exl next cycle
    exlAfterException: assert property (@(posedge clk) disable iff (rst)
        (dataM[0].valid && dataM[0].cp0Type == commitPkg::CP0_EXCEPTION) |=> exl)
        else $error("exl not set one cycle after a slot 0 exception");

    // events only arrive in slot 0 and never write a register
    noWriteOnEvent0: assert property (@(posedge clk) disable iff (rst)
        (dataM[0].cp0Type == commitPkg::CP0_EXCEPTION ||
         dataM[0].cp0Type == commitPkg::CP0_ERET) |-> !dataW[0].valid)
        else $error("slot 0 register write enabled during exception or eret");

endmodule

bind commitTop commitTopProperties commitTopProperties_i (
    .clk(clk),
    .rst(rst),
    .dataM(dataM),
    .dataW(dataW),
    .raddr(raddr),
    .rdata(rdata),
    .exl(exl)
);
